// File: hdl/vita_tx_defines.svh
`ifndef VITA_TX_DEFINES_SVH
`define VITA_TX_DEFINES_SVH

// sample slots per output line
`define VITA_MAXCHAN 4

// lines held by the output FIFO
`define VITA_FIFO_DEPTH 16

// settings bus addresses
`define VITA_SR_NUMCHAN 8'h00  // channel count minus one
`define VITA_SR_SEQCLR  8'h01  // any write restarts count tracking

`endif

// File: hdl/vita_hdr_pkg.sv
`default_nettype none

package vita_hdr_pkg;

   typedef logic [15:0] vita_len_t;    // words, header included
   typedef logic [3:0]  vita_count_t;
   typedef logic [63:0] vita_time_t;   // secs high, tics low

   typedef struct packed {
      logic has_streamid;
      logic has_classid;
      logic has_secs;
      logic has_tics;
      logic has_trailer;
      logic is_sob;
      logic is_eob;
   } vita_hdr_flags_t;

   // header fields first, in wire order
   typedef enum logic [3:0] {
      HEADER,
      STREAMID,
      CLASSID,
      CLASSID2,
      SECS,
      TICS,
      TICS2,
      PAYLOAD,
      STORE,
      TRAILER,
      DUMP
   } deframe_state_t;

endpackage

`default_nettype wire

// File: hdl/vita_line_pkg.sv
`default_nettype none

`include "vita_tx_defines.svh"

package vita_line_pkg;
   import vita_hdr_pkg::*;

   typedef logic [31:0] vita_sample_t;
   typedef logic [1:0]  numchan_t;
   typedef logic [15:0] fifo_level_t;

   typedef struct packed {
      logic [1:0]   spare;
      logic         eof;
      logic         sof;
      logic [31:0]  data;
   } bus_word_t;

   typedef struct packed {
      vita_sample_t [`VITA_MAXCHAN-1:0] samples;  // slot 0 lowest
      logic         seq_err;
      logic         send_at;
      logic         sob;
      logic         eob;
      logic         eop;
      logic [11:0]  spare;   // always zero
      vita_count_t  count;
      vita_time_t   send_time;
   } tx_line_t;

endpackage

`default_nettype wire

// File: hdl/vita_settings.sv
`default_nettype none

`include "vita_tx_defines.svh"

module vita_settings
   import vita_line_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic        set_stb_i,
   input  wire logic [7:0]  set_addr_i,
   input  wire logic [31:0] set_data_i,
   output numchan_t         numchan_o,
   output logic             seq_clr_o
);

   logic numchan_hit;
   logic seqclr_hit;

   assign numchan_hit = set_stb_i & (set_addr_i == `VITA_SR_NUMCHAN);
   assign seqclr_hit  = set_stb_i & (set_addr_i == `VITA_SR_SEQCLR);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         numchan_o <= '0;
         seq_clr_o <= 1'b0;
      end
      else
      begin
         if (numchan_hit)
            numchan_o <= numchan_t'(set_data_i[1:0]);
         seq_clr_o <= seqclr_hit;  // data is ignored
      end
   end

endmodule

`default_nettype wire

// File: hdl/vita_seq_check.sv
`default_nettype none

module vita_seq_check
   import vita_hdr_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic        clear_i,
   input  wire logic        seq_clr_i,
   input  wire logic        hdr_stb_i,
   input  wire vita_count_t hdr_count_i,
   output vita_count_t      count_o,
   output logic             seq_err_o
);

   vita_count_t expected;

   assign expected = count_o + 4'd1;  // wraps at 16

   always_ff @(posedge clk)
   begin
      if (reset_i | clear_i | seq_clr_i)
      begin
         // next expected count is then 0
         count_o   <= 4'hF;
         seq_err_o <= 1'b0;
      end
      else if (hdr_stb_i)
      begin
         count_o   <= hdr_count_i;
         seq_err_o <= (hdr_count_i != expected);  // per packet
      end
   end

endmodule

`default_nettype wire

// File: hdl/vita_tx_deframer.sv
`default_nettype none

`include "vita_tx_defines.svh"

module vita_tx_deframer
   import vita_hdr_pkg::*, vita_line_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic        clear_i,
   input  wire numchan_t    numchan_i,
   input  wire bus_word_t   data_i,
   input  wire logic        src_rdy_i,
   output logic             dst_rdy_o,
   output logic             hdr_stb_o,
   output vita_count_t      hdr_count_o,
   input  wire logic        seq_err_i,
   input  wire vita_count_t count_i,
   output tx_line_t         line_o,
   output logic             store_o,
   input  wire logic        fifo_space_i
);

   deframe_state_t  state;
   vita_hdr_flags_t flags;
   vita_hdr_flags_t hdr_flags;
   vita_len_t       remain;        // words still to come, current one included
   numchan_t        phase;
   logic            eop_q;
   logic            eof_q;
   logic            xfer;
   logic            line_done;
   logic            payload_last;
   vita_time_t      send_time;
   vita_sample_t [`VITA_MAXCHAN-1:0] samples_q;

   // earliest optional header word still ahead of cur
   function automatic deframe_state_t next_field(input vita_hdr_flags_t f,
                                                 input deframe_state_t cur);
      deframe_state_t nxt;
      nxt = PAYLOAD;
      if (f.has_tics && cur < TICS)
         nxt = TICS;
      if (f.has_secs && cur < SECS)
         nxt = SECS;
      if (f.has_classid && cur < CLASSID)
         nxt = CLASSID;
      if (f.has_streamid && cur < STREAMID)
         nxt = STREAMID;
      return nxt;
   endfunction

   assign hdr_flags.has_streamid = (data_i.data[31:28] == 4'b0001);
   assign hdr_flags.has_classid  = data_i.data[27];
   assign hdr_flags.has_trailer  = data_i.data[26];
   assign hdr_flags.is_sob       = data_i.data[25];
   assign hdr_flags.is_eob       = data_i.data[24];
   assign hdr_flags.has_secs     = (data_i.data[23:22] != 2'b00);
   assign hdr_flags.has_tics     = (data_i.data[21:20] != 2'b00);

   assign dst_rdy_o    = (state != STORE);  // stall while a line waits for space
   assign xfer         = src_rdy_i & dst_rdy_o;
   assign line_done    = (phase == numchan_i);
   assign payload_last = (remain == vita_len_t'(flags.has_trailer) + 16'd1);

   assign hdr_stb_o   = (state == HEADER) & xfer;
   assign hdr_count_o = data_i.data[19:16];
   assign store_o     = (state == STORE) & fifo_space_i;

   always_ff @(posedge clk)
   begin
      if (reset_i | clear_i)
      begin
         state  <= HEADER;
         flags  <= '0;
         remain <= '0;
         phase  <= '0;
         eop_q  <= 1'b0;
         eof_q  <= 1'b0;
      end
      else
      begin
         if (xfer && state != HEADER)
            remain <= remain - 16'd1;
         case (state)
            HEADER:
               if (xfer)
               begin
                  flags  <= hdr_flags;
                  remain <= data_i.data[15:0] - 16'd1;
                  phase  <= '0;
                  eop_q  <= 1'b0;
                  eof_q  <= 1'b0;
                  state  <= next_field(hdr_flags, HEADER);
               end
            STREAMID, CLASSID2, SECS:
               if (xfer)
                  state <= next_field(flags, state);
            CLASSID:
               if (xfer)
                  state <= CLASSID2;
            TICS:
               if (xfer)
                  state <= TICS2;
            TICS2:
               if (xfer)
                  state <= PAYLOAD;
            PAYLOAD:
               if (xfer)
               begin
                  if (line_done | payload_last | data_i.eof)
                  begin
                     phase <= '0;
                     eop_q <= payload_last | data_i.eof;
                     eof_q <= data_i.eof;
                     state <= STORE;
                  end
                  else
                     phase <= phase + 2'd1;
               end
            STORE:
               if (fifo_space_i)
               begin
                  if (!eop_q)
                     state <= PAYLOAD;
                  else if (eof_q)
                     state <= HEADER;
                  else if (flags.has_trailer)
                     state <= TRAILER;
                  else
                     state <= DUMP;
               end
            TRAILER:
               if (xfer)
                  state <= data_i.eof ? HEADER : DUMP;
            DUMP:
               if (xfer && data_i.eof)
                  state <= HEADER;
            default:
               state <= HEADER;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         case (state)
            HEADER:  send_time <= '0;  // no timestamp means zero
            SECS:    send_time[63:32] <= data_i.data;
            TICS2:   send_time[31:0]  <= data_i.data;
            PAYLOAD: samples_q[phase] <= data_i.data;
            default: ;
         endcase
      end
   end

   always_comb
   begin
      line_o           = '0;
      line_o.samples   = samples_q;
      line_o.seq_err   = seq_err_i;
      line_o.send_at   = flags.has_secs;
      line_o.sob       = flags.is_sob;
      line_o.eob       = flags.is_eob;
      line_o.eop       = eop_q;
      line_o.count     = count_i;
      line_o.send_time = send_time;
   end

endmodule

`default_nettype wire

// File: hdl/vita_line_fifo.sv
`default_nettype none

`include "vita_tx_defines.svh"

module vita_line_fifo
   import vita_line_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset_i,
   input  wire logic     clear_i,
   input  wire tx_line_t line_i,
   input  wire logic     push_i,
   output logic          space_o,
   output tx_line_t      line_o,
   output logic          src_rdy_o,
   input  wire logic     dst_rdy_i,
   output fifo_level_t   occupied_o,
   output logic          full_o,
   output logic          empty_o
);

   localparam int AW = $clog2(`VITA_FIFO_DEPTH);

   tx_line_t       mem [`VITA_FIFO_DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic           push_ok;
   logic           pop_ok;
   fifo_level_t    level_next;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(`VITA_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push_ok    = push_i & ~full_o;
   assign pop_ok     = src_rdy_o & dst_rdy_i;
   assign level_next = occupied_o + fifo_level_t'(push_ok) - fifo_level_t'(pop_ok);

   assign space_o   = ~full_o;
   assign src_rdy_o = ~empty_o;
   assign line_o    = mem[rd_ptr];  // head shows the cycle after its push

   always_ff @(posedge clk)
   begin
      if (push_ok)
         mem[wr_ptr] <= line_i;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i | clear_i)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         occupied_o <= '0;
         full_o     <= 1'b0;
         empty_o    <= 1'b1;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop_ok)
            rd_ptr <= ptr_inc(rd_ptr);
         occupied_o <= level_next;
         full_o     <= (level_next == fifo_level_t'(`VITA_FIFO_DEPTH));
         empty_o    <= (level_next == '0);
      end
   end

endmodule

`default_nettype wire

// File: hdl/vita_tx_top.sv
`default_nettype none

module vita_tx_top
   import vita_hdr_pkg::*, vita_line_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic        clear_i,
   input  wire logic        set_stb_i,
   input  wire logic [7:0]  set_addr_i,
   input  wire logic [31:0] set_data_i,
   input  wire bus_word_t   data_i,
   input  wire logic        src_rdy_i,
   output logic             dst_rdy_o,
   output tx_line_t         sample_line_o,
   output logic             line_src_rdy_o,
   input  wire logic        line_dst_rdy_i,
   output vita_count_t      current_count_o,
   output fifo_level_t      fifo_occupied_o,
   output logic             fifo_full_o,
   output logic             fifo_empty_o
);

   numchan_t    numchan;
   logic        seq_clr;
   logic        hdr_stb;
   vita_count_t hdr_count;
   logic        seq_err;
   vita_count_t count_reg;
   tx_line_t    line;
   logic        store;
   logic        fifo_space;

   assign current_count_o = count_reg;

   vita_settings settings_i (
      .clk        (clk),
      .reset_i    (reset_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .numchan_o  (numchan),
      .seq_clr_o  (seq_clr)
   );

   vita_tx_deframer deframer_i (
      .clk          (clk),
      .reset_i      (reset_i),
      .clear_i      (clear_i),
      .numchan_i    (numchan),
      .data_i       (data_i),
      .src_rdy_i    (src_rdy_i),
      .dst_rdy_o    (dst_rdy_o),
      .hdr_stb_o    (hdr_stb),
      .hdr_count_o  (hdr_count),
      .seq_err_i    (seq_err),
      .count_i      (count_reg),
      .line_o       (line),
      .store_o      (store),
      .fifo_space_i (fifo_space)
   );

   vita_seq_check seq_check_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .clear_i     (clear_i),
      .seq_clr_i   (seq_clr),
      .hdr_stb_i   (hdr_stb),
      .hdr_count_i (hdr_count),
      .count_o     (count_reg),
      .seq_err_o   (seq_err)
   );

   vita_line_fifo line_fifo_i (
      .clk        (clk),
      .reset_i    (reset_i),
      .clear_i    (clear_i),
      .line_i     (line),
      .push_i     (store),
      .space_o    (fifo_space),
      .line_o     (sample_line_o),
      .src_rdy_o  (line_src_rdy_o),
      .dst_rdy_i  (line_dst_rdy_i),
      .occupied_o (fifo_occupied_o),
      .full_o     (fifo_full_o),
      .empty_o    (fifo_empty_o)
   );

endmodule

`default_nettype wire

// File: testbench/vita_tx_assertions.sv
`default_nettype none

`include "vita_tx_defines.svh"

module vita_tx_assertions
   import vita_line_pkg::*;
(
   input wire logic        clk,
   input wire logic        reset_i,
   input wire bus_word_t   in_word_i,
   input wire logic        in_valid_i,
   input wire logic        in_ready_i,
   input wire tx_line_t    out_line_i,
   input wire logic        out_valid_i,
   input wire logic        out_ready_i,
   input wire fifo_level_t occupied_i,
   input wire logic        full_i,
   input wire logic        empty_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // a stalled transfer keeps valid and data
   assert property (@(posedge clk) disable iff (reset_i)
      in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_word_i))
      else $error("input word dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (reset_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_line_i))
      else $error("output line dropped or changed while stalled");

   assert property (@(posedge clk) disable iff (reset_i) !(full_i && empty_i))
      else $error("FIFO full and empty at once");

   assert property (@(posedge clk) disable iff (reset_i)
      occupied_i <= fifo_level_t'(`VITA_FIFO_DEPTH))
      else $error("FIFO occupancy above depth");

endmodule

`default_nettype wire

// File: testbench/tb_vita_tx.sv
`default_nettype none

`include "vita_tx_defines.svh"

module tb_vita_tx
   import vita_hdr_pkg::*, vita_line_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PKTS_PER_RUN   = 12;
   localparam int RUNS           = 5;  // channel counts 1 to 4 and a stall run
   localparam int TIMEOUT_CYCLES = 40 * PKTS_PER_RUN * RUNS + 200;

   logic        clk = 1'b0;
   logic        reset_i;
   logic        clear_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   bus_word_t   data_i;
   logic        src_rdy_i;
   logic        dst_rdy_o;
   tx_line_t    sample_line_o;
   logic        line_src_rdy_o;
   logic        line_dst_rdy_i;
   vita_count_t current_count_o;
   fifo_level_t fifo_occupied_o;
   logic        fifo_full_o;
   logic        fifo_empty_o;

   integer      seed = 32'h1232e5ad;
   tx_line_t    exp_q[$];
   tx_line_t    head;
   vita_count_t prev_count = 4'hF;  // so the first expected count is 0
   int          nchan = 1;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          stall_left = 0;
   logic        stall_mode = 1'b0;
   logic        gaps_on = 1'b1;
   logic        saw_full = 1'b0;
   logic        next_ready;
   logic [31:0] cr;

   vita_tx_top dut_i (.*);

   bind vita_tx_top vita_tx_assertions assertions_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_word_i   (data_i),
      .in_valid_i  (src_rdy_i),
      .in_ready_i  (dst_rdy_o),
      .out_line_i  (sample_line_o),
      .out_valid_i (line_src_rdy_o),
      .out_ready_i (line_dst_rdy_i),
      .occupied_i  (fifo_occupied_o),
      .full_i      (fifo_full_o),
      .empty_i     (fifo_empty_o)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles with %0d lines still expected", cycles, exp_q.size());
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_line(input tx_line_t got, input tx_line_t exp);
      for (int i = 0; i < nchan; i++)  // unused slots are don't care
         check_value($sformatf("samples[%0d]", i), 64'(got.samples[i]), 64'(exp.samples[i]));
      check_value("seq_err", 64'(got.seq_err), 64'(exp.seq_err));
      check_value("send_at", 64'(got.send_at), 64'(exp.send_at));
      check_value("sob", 64'(got.sob), 64'(exp.sob));
      check_value("eob", 64'(got.eob), 64'(exp.eob));
      check_value("eop", 64'(got.eop), 64'(exp.eop));
      check_value("count", 64'(got.count), 64'(exp.count));
      check_value("send_time", got.send_time, exp.send_time);
   endtask

   // valid stays up until the word is taken
   task automatic send_word(input bus_word_t w);
      logic [31:0] r;
      logic        done;
      data_i = w;
      r = $random(seed);
      src_rdy_i = !gaps_on || r[1:0] != 2'b00;
      done = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         done = src_rdy_i & dst_rdy_o;
         @(posedge clk);
         #1;
         if (!src_rdy_i)
         begin
            r = $random(seed);
            src_rdy_i = r[1:0] != 2'b00;
         end
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] value);
      set_stb_i = 1'b1;
      set_addr_i = addr;
      set_data_i = value;
      @(posedge clk);
      #1;
      set_stb_i = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic send_packet();
      logic [31:0] r;
      logic [31:0] hdr;
      logic [31:0] secs;
      logic [31:0] tics;
      logic [31:0] words[$];
      tx_line_t    line;
      vita_count_t cnt;
      int          n_lines;
      int          len;
      bus_word_t   w;
      r = $random(seed);
      cnt = (r[2:0] == 3'd0) ? prev_count + 4'd2 + {2'b00, r[4:3]} : prev_count + 4'd1;
      hdr = '0;
      hdr[31:28] = r[5] ? 4'b0001 : 4'b0000;
      hdr[27:20] = r[13:6];  // class id, trailer, sob, eob, time fields
      hdr[19:16] = cnt;
      n_lines = 1 + int'(r[15:14]);
      secs = $random(seed);
      tics = $random(seed);
      len = 1 + int'(hdr[31:28] == 4'b0001) + 2 * int'(hdr[27]) + int'(hdr[23:22] != 2'b00)
            + 2 * int'(hdr[21:20] != 2'b00) + n_lines * nchan + int'(hdr[26]);
      hdr[15:0] = 16'(len);
      words.push_back(hdr);
      if (hdr[31:28] == 4'b0001)
         words.push_back($random(seed));
      if (hdr[27])
      begin
         words.push_back($random(seed));
         words.push_back($random(seed));
      end
      if (hdr[23:22] != 2'b00)
         words.push_back(secs);
      if (hdr[21:20] != 2'b00)
      begin
         words.push_back($random(seed));
         words.push_back(tics);  // low half of send time
      end
      for (int l = 0; l < n_lines; l++)
      begin
         line = '0;
         for (int s = 0; s < nchan; s++)
         begin
            line.samples[s] = $random(seed);
            words.push_back(line.samples[s]);
         end
         line.seq_err   = (cnt != prev_count + 4'd1);
         line.send_at   = (hdr[23:22] != 2'b00);
         line.sob       = hdr[25];
         line.eob       = hdr[24];
         line.eop       = (l == n_lines - 1);
         line.count     = cnt;
         line.send_time = {line.send_at ? secs : 32'd0, (hdr[21:20] != 2'b00) ? tics : 32'd0};
         exp_q.push_back(line);
      end
      if (hdr[26])
         words.push_back($random(seed));
      if (r[17:16] == 2'b00)  // surplus words past the length
         repeat (1 + int'(r[18]))
            words.push_back($random(seed));
      for (int i = 0; i < words.size(); i++)
      begin
         w = '0;
         w.sof = (i == 0);
         w.eof = (i == words.size() - 1);
         w.data = words[i];
         send_word(w);
      end
      prev_count = cnt;
   endtask

   task automatic drain();
      src_rdy_i = 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
      #1;
   endtask

   // output checker and random line_dst_rdy_i
   initial
   begin
      line_dst_rdy_i = 1'b0;
      forever
      begin
         @(negedge clk);
         if (!reset_i && line_src_rdy_o && line_dst_rdy_i)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("Output line at %0t arrived with no line expected", $time);
            end
            else
            begin
               head = exp_q.pop_front();
               compare_line(sample_line_o, head);
            end
         end
         if (fifo_full_o)
         begin
            saw_full = 1'b1;
            check_value("fifo_occupied_o", 64'(fifo_occupied_o), 64'(`VITA_FIFO_DEPTH));
         end
         cr = $random(seed);
         if (stall_left > 0)
            stall_left--;
         else if (stall_mode && cr[3:0] == 4'd0)
            stall_left = 64 + int'(cr[9:4]);  // long stall
         next_ready = (stall_left == 0) && (stall_mode ? cr[31] : cr[31:30] != 2'b00);
         @(posedge clk);
         #1;
         line_dst_rdy_i = next_ready;
      end
   end

   initial
   begin
      reset_i = 1'b1;
      clear_i = 1'b0;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      data_i = '0;
      src_rdy_i = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset_i = 1'b0;
      check_value("dst_rdy_o", 64'(dst_rdy_o), 64'd1);
      check_value("line_src_rdy_o", 64'(line_src_rdy_o), 64'd0);
      for (int run = 0; run < RUNS; run++)
      begin
         nchan = (run < 4) ? run + 1 : 1;
         stall_mode = (run == RUNS - 1);
         gaps_on = !stall_mode;  // source runs flat out to fill the FIFO
         write_setting(`VITA_SR_NUMCHAN, 32'(nchan - 1));
         if (run == 2)
         begin
            write_setting(`VITA_SR_SEQCLR, 32'hFFFF_FFFF);
            prev_count = 4'hF;
         end
         repeat (PKTS_PER_RUN) send_packet();
         drain();
         check_value("current_count_o", 64'(current_count_o), 64'(prev_count));
      end
      check_value("fifo_empty_o", 64'(fifo_empty_o), 64'd1);
      check_value("fifo_occupied_o", 64'(fifo_occupied_o), 64'd0);
      if (!saw_full)
      begin
         errors++;
         $display("fifo_full_o was never seen during the stall run");
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/vita_hdr_pkg.sv
hdl/vita_line_pkg.sv
hdl/vita_settings.sv
hdl/vita_seq_check.sv
hdl/vita_tx_deframer.sv
hdl/vita_line_fifo.sv
hdl/vita_tx_top.sv
testbench/vita_tx_assertions.sv
testbench/tb_vita_tx.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_vita_tx
RTL_TOP    := vita_tx_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
PASS_MSG   := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
